//--- common/game_pkg.sv
// ****************************************
// shared definitions of the penalty game
// core: phase and mode encodings, the
// register map and the limit reset values
// ****************************************

package game_pkg;

    // game phase, as seen by controller and tracker
    typedef enum logic [2:0] {
        START   = 3'd0,
        KEEPER  = 3'd1,
        SHOOTER = 3'd2,
        WINNER  = 3'd3,
        LOOSER  = 3'd4
    } g_state;

    // play mode, multi needs the link between boards
    typedef enum logic {
        MULTI = 1'b0,
        SOLO  = 1'b1
    } g_mode;

    // byte offsets of the register map
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_LIMITS = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;

    // saves needed to win
    localparam logic [3:0] WIN_SCORE_RST   = 4'd5;
    // rounds before the keeper loses
    localparam logic [3:0] ROUND_LIMIT_RST = 4'd9;

endpackage

//--- game_regs/game_regs.sv
// ****************************************
// AXI4-Lite register block of the game:
// solo enable, game limits, live status
// ****************************************

`timescale 1ns/10ps

module game_regs
    import game_pkg::*;
#(
    parameter int ROUND_W = 4,
    parameter int SCORE_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [3:0]         awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  logic [3:0]         araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic [31:0]        rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    input  g_state             game_state,
    input  g_mode              game_mode,
    input  logic [SCORE_W-1:0] score,
    input  logic [ROUND_W-1:0] round_counter,
    output logic               solo_enable,
    output logic [SCORE_W-1:0] win_score,
    output logic [ROUND_W-1:0] round_limit
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_fire;
    logic        rd_fire;
    logic        wr_mapped;
    logic [31:0] status_word;
    logic [31:0] rd_word;
    logic [1:0]  rd_resp;

    // address and data accepted together
    assign wr_fire   = awready && awvalid && wvalid;
    assign rd_fire   = arready && arvalid;
    assign wr_mapped = (awaddr == REG_CTRL) || (awaddr == REG_LIMITS) ||
                       (awaddr == REG_STATUS);

    always_comb begin
        status_word                 = '0;
        status_word[2:0]            = game_state;
        status_word[4]              = game_mode;
        status_word[8 +: SCORE_W]   = score;
        status_word[16 +: ROUND_W]  = round_counter;
    end

    // read mux, status sampled here
    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_CTRL:   rd_word[0] = solo_enable;
            REG_LIMITS: begin
                rd_word[0 +: SCORE_W] = win_score;
                rd_word[8 +: ROUND_W] = round_limit;
            end
            REG_STATUS: rd_word = status_word;
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            solo_enable <= 1'b0;
            win_score   <= SCORE_W'(WIN_SCORE_RST);
            round_limit <= ROUND_W'(ROUND_LIMIT_RST);
        end else begin
            // write path, one beat at a time
            if (awready) begin
                awready <= 1'b0;
                wready  <= 1'b0;
            end else if (awvalid && wvalid && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                case (awaddr)
                    REG_CTRL: if (wstrb[0]) solo_enable <= wdata[0];
                    REG_LIMITS: begin
                        if (wstrb[0]) win_score <= wdata[0 +: SCORE_W];
                        if (wstrb[1]) round_limit <= wdata[8 +: ROUND_W];
                    end
                    // status is read only
                    default: ;
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            // read path
            if (arready) begin
                arready <= 1'b0;
            end else if (arvalid && !rvalid) begin
                arready <= 1'b1;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
        else $error("read response changed before rready");

endmodule

//--- design/round_tracker.sv
// ****************************************
// round tracker: counts keeper rounds and
// pulses each round's outcome
// ****************************************

`timescale 1ns/10ps

module round_tracker
    import game_pkg::*;
#(
    parameter int ROUND_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               shot_valid,
    input  logic               shot_saved,
    input  g_state             game_state,
    input  logic [ROUND_W-1:0] round_limit,
    output logic               round_done,
    output logic               is_scored,
    output logic [ROUND_W-1:0] round_counter
);

    logic shot_take;

    // shots only count while the keeper is playing
    assign shot_take = shot_valid && (game_state == KEEPER);

    always_ff @(posedge clk) begin
        if (rst) begin
            round_done    <= 1'b0;
            is_scored     <= 1'b0;
            round_counter <= '0;
        end else begin
            // outcome pulse, one cycle after the shot
            round_done <= shot_take;
            is_scored  <= shot_take && !shot_saved;
            if (game_state == START) begin
                round_counter <= '0;
            end else if (shot_take && (round_counter < round_limit)) begin
                // saturates at the limit
                round_counter <= round_counter + 1'b1;
            end
        end
    end

    // shot_valid comes as isolated pulses from the shooting logic
    assert property (@(posedge clk) disable iff (rst)
        round_done |=> !round_done)
        else $error("round_done high on two cycles in a row");

    assert property (@(posedge clk) disable iff (rst)
        round_counter <= round_limit)
        else $error("round_counter above round_limit");

endmodule

//--- design/game_state_sel.sv
// ****************************************
// game state controller for solo keeper
// mode: phase FSM, save score and mode
// latching while in START
// ****************************************

`timescale 1ns/10ps

module game_state_sel
    import game_pkg::*;
#(
    parameter int ROUND_W = 4,
    parameter int SCORE_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               click,
    input  logic               solo_enable,
    input  logic [SCORE_W-1:0] win_score,
    input  logic [ROUND_W-1:0] round_limit,
    input  logic               round_done,
    input  logic               is_scored,
    output g_state             game_state,
    output g_mode              game_mode,
    output logic [SCORE_W-1:0] score
);

    g_state             game_state_nxt;
    g_mode              game_mode_nxt;
    logic [SCORE_W-1:0] score_nxt;
    logic [SCORE_W-1:0] score_inc;
    logic [ROUND_W-1:0] rounds_q;
    logic [ROUND_W-1:0] rounds_nxt;
    logic [ROUND_W-1:0] rounds_inc;
    logic               click_r;
    logic               click_rr;
    logic               click_rise;

    // click level staged twice, edge taken between the stages
    assign click_rise = click_r && !click_rr;
    assign score_inc  = score + 1'b1;
    assign rounds_inc = rounds_q + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            click_r    <= 1'b0;
            click_rr   <= 1'b0;
            game_state <= START;
            game_mode  <= MULTI;
            score      <= '0;
            rounds_q   <= '0;
        end else begin
            click_r    <= click;
            click_rr   <= click_r;
            game_state <= game_state_nxt;
            game_mode  <= game_mode_nxt;
            score      <= score_nxt;
            rounds_q   <= rounds_nxt;
        end
    end

    // solo only taken in START, dropping the enable forces multi at once
    always_comb begin
        if (!solo_enable) begin
            game_mode_nxt = MULTI;
        end else if (game_state == START) begin
            game_mode_nxt = SOLO;
        end else begin
            game_mode_nxt = game_mode;
        end
    end

    always_comb begin
        game_state_nxt = game_state;
        score_nxt      = score;
        rounds_nxt     = rounds_q;
        if (game_mode == MULTI) begin
            // no link here, so multi parks in START
            game_state_nxt = START;
            score_nxt      = '0;
            rounds_nxt     = '0;
        end else begin
            case (game_state)
                START: begin
                    rounds_nxt = '0;
                    if (click_rise) begin
                        game_state_nxt = KEEPER;
                        score_nxt      = '0;
                    end
                end
                KEEPER: begin
                    if (round_done) begin
                        // private round count, mirrors the tracker saturation
                        if (rounds_q < round_limit) begin
                            rounds_nxt = rounds_inc;
                        end
                        if (!is_scored) begin
                            score_nxt = score_inc;
                        end
                        // a save that reaches the limit wins even on the last round
                        if (!is_scored && score_inc >= win_score) begin
                            game_state_nxt = WINNER;
                        end else if (rounds_inc >= round_limit) begin
                            game_state_nxt = LOOSER;
                        end
                    end
                end
                WINNER, LOOSER: begin
                    if (click_rise) begin
                        game_state_nxt = START;
                    end
                end
                // shooter belongs to multiplayer
                default: begin
                    game_state_nxt = START;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        game_state inside {START, KEEPER, SHOOTER, WINNER, LOOSER})
        else $error("game_state holds an illegal encoding");

    // limits are only rewritten between games
    assert property (@(posedge clk) disable iff (rst)
        (game_state == KEEPER) |-> (score <= win_score))
        else $error("score above win_score during play");

endmodule

//--- design/penalty_game_top.sv
// ****************************************
// penalty shoot-out game core, solo keeper
// mode: register block, round tracker and
// game state controller
// ****************************************

`timescale 1ns/10ps

module penalty_game_top
    import game_pkg::*;
#(
    parameter int ROUND_W = 4,
    parameter int SCORE_W = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        click,
    input  logic        shot_valid,
    input  logic        shot_saved,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    g_state             game_state;
    g_mode              game_mode;
    logic [SCORE_W-1:0] score;
    logic [SCORE_W-1:0] win_score;
    logic [ROUND_W-1:0] round_limit;
    logic [ROUND_W-1:0] round_counter;
    logic               solo_enable;
    logic               round_done;
    logic               is_scored;

    // cpu side config and status
    game_regs #(
        .ROUND_W(ROUND_W),
        .SCORE_W(SCORE_W)
    ) u_game_regs (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .game_state, .game_mode, .score, .round_counter,
        .solo_enable, .win_score, .round_limit
    );

    // shot outcomes into rounds
    round_tracker #(
        .ROUND_W(ROUND_W)
    ) u_round_tracker (
        .clk, .rst,
        .shot_valid, .shot_saved, .game_state, .round_limit,
        .round_done, .is_scored, .round_counter
    );

    game_state_sel #(
        .ROUND_W(ROUND_W),
        .SCORE_W(SCORE_W)
    ) u_game_state_sel (
        .clk, .rst,
        .click, .solo_enable, .win_score, .round_limit,
        .round_done, .is_scored,
        .game_state, .game_mode, .score
    );

endmodule

//--- bench/penalty_game_tb.sv
// ****************************************
// testbench of the penalty game core:
// table of AXI4-Lite accesses, clicks and
// shots checked against a reference model
// ****************************************

`timescale 1ns/10ps

module penalty_game_tb
    import game_pkg::*;
;

    localparam int WAIT_MAX = 50;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_CLICK, OP_SHOT, OP_BURST} op_e;

    // addr doubles as shot outcome, exp is a response code or a state
    typedef struct packed {
        op_e         op;
        logic [3:0]  addr;
        logic [3:0]  strb;
        logic [3:0]  hold;
        logic [31:0] data;
        logic [31:0] exp;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        click;
    logic        shot_valid;
    logic        shot_saved;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    entry_t      tbl[$];
    int          errors = 0;
    int          tests = 0;
    logic [7:0]  lfsr_q = 8'd81;

    // reference model
    g_state      m_state = START;
    g_mode       m_mode = MULTI;
    logic [3:0]  m_score = '0;
    logic [3:0]  m_rounds = '0;
    logic        m_solo = 1'b0;
    logic [3:0]  m_win = WIN_SCORE_RST;
    logic [3:0]  m_limit = ROUND_LIMIT_RST;

    penalty_game_top penalty_game_top_i (.*);

    always #2 clk = ~clk;

    // x^8 + x^6 + x^5 + x^4 + 1, Galois form
    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    function automatic logic [31:0] model_word(logic [3:0] addr);
        case (addr)
            REG_CTRL:   return {31'b0, m_solo};
            REG_LIMITS: return {20'b0, m_limit, 4'b0, m_win};
            REG_STATUS: return {12'b0, m_rounds, 4'b0, m_score, 3'b0, m_mode, 1'b0, m_state};
            default:    return '0;
        endcase
    endfunction

    // mode follows the enable, solo only taken in START
    task automatic model_settle();
        if (!m_solo) begin
            m_mode = MULTI;
        end else if (m_state == START) begin
            m_mode = SOLO;
        end
        if (m_mode == MULTI) begin
            m_state = START;
            m_score = '0;
        end
        if (m_state == START) begin
            m_rounds = '0;
        end
    endtask

    task automatic model_write(logic [3:0] addr, logic [31:0] data, logic [3:0] strb);
        if (addr == REG_CTRL && strb[0]) begin
            m_solo = data[0];
        end
        if (addr == REG_LIMITS && strb[0]) begin
            m_win = data[3:0];
        end
        if (addr == REG_LIMITS && strb[1]) begin
            m_limit = data[11:8];
        end
        model_settle();
    endtask

    task automatic model_click();
        if (m_mode == SOLO && m_state == START) begin
            m_state = KEEPER;
            m_score = '0;
        end else if (m_mode == SOLO && (m_state == WINNER || m_state == LOOSER)) begin
            m_state = START;
        end
        model_settle();
    endtask

    task automatic model_shot(logic saved);
        if (m_state == KEEPER) begin
            if (m_rounds < m_limit) begin
                m_rounds = m_rounds + 1'b1;
            end
            if (saved) begin
                m_score = m_score + 1'b1;
            end
            if (saved && m_score >= m_win) begin
                m_state = WINNER;
            end else if (m_rounds >= m_limit) begin
                m_state = LOOSER;
            end
        end
    endtask

    task automatic check_state(g_state got, g_state exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_mode(g_mode got, g_mode exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_hang(string what);
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_MAX);
        errors++;
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic axi_write(logic [3:0] addr, logic [31:0] data, logic [3:0] strb,
                             int hold, output logic [1:0] resp);
        int cnt;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        cnt = 0;
        while (!awready && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (!awready) begin
            report_hang("write address handshake");
        end else begin
            // data channel accepted in the same cycle as the address
            check_word({31'b0, wready}, 32'h1, "wready with awready");
        end
        @(negedge clk);
        // ready is a single-cycle pulse
        check_word({31'b0, wready}, 32'h0, "wready after accept");
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cnt = 0;
        while (!bvalid && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (!bvalid) report_hang("write response");
        resp = bresp;
        // back-pressure, response must hold
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            if (!bvalid) begin
                $display("bvalid dropped at %0t while bready was low", $time);
                errors++;
            end
            check_word({30'b0, bresp}, {30'b0, resp}, "held bresp");
        end
        bready = 1'b1;
        cnt = 0;
        while (bvalid && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (bvalid) report_hang("write response release");
        bready = 1'b0;
    endtask

    task automatic axi_read(logic [3:0] addr, int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int cnt;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        cnt = 0;
        while (!arready && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (!arready) report_hang("read address handshake");
        @(negedge clk);
        arvalid = 1'b0;
        cnt = 0;
        while (!rvalid && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (!rvalid) report_hang("read data");
        data = rdata;
        resp = rresp;
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            if (!rvalid) begin
                $display("rvalid dropped at %0t while rready was low", $time);
                errors++;
            end
            check_word(rdata, data, "held rdata");
            check_word({30'b0, rresp}, {30'b0, resp}, "held rresp");
        end
        rready = 1'b1;
        cnt = 0;
        while (rvalid && cnt < WAIT_MAX) begin
            @(negedge clk);
            cnt++;
        end
        if (rvalid) report_hang("read data release");
        rready = 1'b0;
    endtask

    // level held for several cycles, only one edge
    task automatic click_pulse();
        click = 1'b1;
        idle(4);
        click = 1'b0;
        idle(3);
    endtask

    task automatic shot_pulse(logic saved);
        shot_valid = 1'b1;
        shot_saved = saved;
        @(negedge clk);
        shot_valid = 1'b0;
        shot_saved = 1'b0;
        idle(3);
    endtask

    task automatic add_write(logic [3:0] addr, logic [3:0] strb, logic [31:0] data,
                             logic [1:0] resp, logic [3:0] hold);
        tbl.push_back('{OP_WRITE, addr, strb, hold, data, {30'b0, resp}});
    endtask

    task automatic add_read(logic [3:0] addr, logic [1:0] resp, logic [3:0] hold);
        tbl.push_back('{OP_READ, addr, 4'h0, hold, 32'h0, {30'b0, resp}});
    endtask

    task automatic add_event(op_e op, logic [3:0] arg, logic [31:0] n, g_state exp);
        tbl.push_back('{op, arg, 4'h0, 4'h0, n, {29'b0, exp}});
    endtask

    initial begin
        entry_t      e;
        op_e         op;
        logic [31:0] word;
        logic [1:0]  resp;
        logic        bit_q;
        int          errs_before;
        clk = 1'b0;
        rst = 1'b1;
        click = 1'b0;
        shot_valid = 1'b0;
        shot_saved = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;

        // reset values, strobes, unmapped and read-only accesses
        add_read(REG_LIMITS, OKAY, 0);
        add_read(REG_CTRL, OKAY, 0);
        add_write(REG_LIMITS, 4'b0001, 32'h0000_0706, OKAY, 0);
        add_read(REG_LIMITS, OKAY, 0);
        add_write(REG_LIMITS, 4'b0010, 32'h0000_0A03, OKAY, 0);
        add_read(REG_LIMITS, OKAY, 0);
        add_write(REG_LIMITS, 4'b0011, 32'h0000_0903, OKAY, 0);
        add_read(4'hC, SLVERR, 0);
        add_write(REG_STATUS, 4'b1111, 32'hFFFF_FFFF, OKAY, 0);
        add_read(REG_STATUS, OKAY, 0);
        // mode latching
        add_write(REG_CTRL, 4'b0001, 32'h1, OKAY, 0);
        add_read(REG_STATUS, OKAY, 0);
        add_event(OP_CLICK, 4'h0, 0, KEEPER);
        add_event(OP_SHOT, 4'h1, 0, KEEPER);
        add_write(REG_CTRL, 4'b0001, 32'h0, OKAY, 0);
        add_read(REG_STATUS, OKAY, 0);
        add_event(OP_CLICK, 4'h0, 0, START);
        add_write(REG_CTRL, 4'b0001, 32'h1, OKAY, 0);
        add_event(OP_CLICK, 4'h0, 0, KEEPER);
        add_write(REG_CTRL, 4'b0001, 32'h1, OKAY, 3);
        add_read(REG_STATUS, OKAY, 3);
        // winning game, then ignored shots
        add_event(OP_SHOT, 4'h0, 0, KEEPER);
        add_event(OP_SHOT, 4'h1, 0, KEEPER);
        add_event(OP_SHOT, 4'h1, 0, KEEPER);
        add_event(OP_SHOT, 4'h1, 0, WINNER);
        add_event(OP_SHOT, 4'h1, 0, WINNER);
        add_event(OP_CLICK, 4'h0, 0, START);
        add_event(OP_SHOT, 4'h0, 0, START);
        // losing games from random shots
        add_write(REG_LIMITS, 4'b0011, 32'h0000_0304, OKAY, 0);
        add_event(OP_CLICK, 4'h0, 0, KEEPER);
        add_event(OP_BURST, 4'h0, 5, LOOSER);
        add_event(OP_CLICK, 4'h0, 0, START);
        add_event(OP_CLICK, 4'h0, 0, KEEPER);
        add_event(OP_BURST, 4'h0, 6, LOOSER);

        repeat (5) @(negedge clk);
        rst = 1'b0;
        idle(2);

        foreach (tbl[i]) begin
            e = tbl[i];
            op = e.op;
            errs_before = errors;
            case (op)
                OP_WRITE: begin
                    axi_write(e.addr, e.data, e.strb, e.hold, resp);
                    idle(4);
                    model_write(e.addr, e.data, e.strb);
                    check_word({30'b0, resp}, e.exp, "bresp");
                end
                OP_READ: begin
                    axi_read(e.addr, e.hold, word, resp);
                    check_word(word, model_word(e.addr), "rdata");
                    check_word({30'b0, resp}, e.exp, "rresp");
                end
                default: begin
                    if (op == OP_CLICK) begin
                        click_pulse();
                        model_click();
                    end else if (op == OP_SHOT) begin
                        shot_pulse(e.addr[0]);
                        model_shot(e.addr[0]);
                    end else begin
                        for (int k = 0; k < e.data; k++) begin
                            bit_q = lfsr_q[0];
                            lfsr_q = lfsr_next(lfsr_q);
                            shot_pulse(bit_q);
                            model_shot(bit_q);
                        end
                    end
                    axi_read(REG_STATUS, 0, word, resp);
                    check_state(g_state'(word[2:0]), g_state'(e.exp[2:0]), "game state");
                    check_mode(g_mode'(word[4]), m_mode, "game mode");
                    check_word(word, model_word(REG_STATUS), "status");
                end
            endcase
            tests++;
            $display("test %0d %s: %s", i, op.name(), (errors == errs_before) ? "ok" : "bad");
        end

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sources.f
common/game_pkg.sv
game_regs/game_regs.sv
design/round_tracker.sv
design/game_state_sel.sv
design/penalty_game_top.sv
bench/penalty_game_tb.sv

//--- Bender.yml
package:
  name: penalty_game

sources:
  - common/game_pkg.sv
  - game_regs/game_regs.sv
  - design/round_tracker.sv
  - design/game_state_sel.sv
  - design/penalty_game_top.sv
  - target: test
    files:
      - bench/penalty_game_tb.sv
